// ==== Bender.yml ====
package:
  name: cpu16

sources:
  - common/cpuPkg.sv
  - decode/controlUnit.sv
  - decode/registerFile.sv
  - decode/branchControl.sv
  - decode/decodeStage.sv
  - src/fetchUnit.sv
  - src/executeStage.sv
  - src/cpuTop.sv
  - target: test
    include_dirs:
      - verification
    files:
      - verification/cpuTb.sv

// ==== common/cpuPkg.sv ====
// ======================================================================
// Shared types for the 16-bit single-cycle core: opcodes, branch
// conditions, the decoded instruction views and the stage structs.
// Imported by every module that passes these signals around.
// ======================================================================

package cpuPkg;

    typedef enum logic [3:0] {
        OpAdd    = 4'h0,
        OpSub    = 4'h1,
        OpXor    = 4'h2,
        OpRed    = 4'h3,
        OpSll    = 4'h4,
        OpSra    = 4'h5,
        OpRor    = 4'h6,
        OpPaddsb = 4'h7,
        OpLw     = 4'h8,
        OpSw     = 4'h9,
        OpLlb    = 4'hA,
        OpLhb    = 4'hB,
        OpB      = 4'hC,
        OpBr     = 4'hD,
        OpPcs    = 4'hE,
        OpHlt    = 4'hF
    } opcodeE;

    typedef enum logic [2:0] {
        CondNe = 3'b000,
        CondEq = 3'b001,
        CondGt = 3'b010,
        CondLt = 3'b011,
        CondGe = 3'b100,
        CondLe = 3'b101,
        CondOv = 3'b110,
        CondAl = 3'b111
    } condE;

    // Branch class carried in ctrlT.branch
    localparam logic [1:0] BranchNone = 2'b00;
    localparam logic [1:0] BranchB    = 2'b01;
    localparam logic [1:0] BranchReg  = 2'b10;
    localparam logic [1:0] BranchHalt = 2'b11;

    typedef struct packed {
        opcodeE     opcode;
        logic [3:0] rd;
        logic [3:0] rs;
        logic [3:0] rt;
    } rFormatT;

    typedef struct packed {
        opcodeE     opcode;
        logic [3:0] rd;
        logic [7:0] imm8;
    } iFormatT;

    typedef struct packed {
        opcodeE     opcode;
        condE       cond;
        logic [8:0] offset;
    } bFormatT;

    // Same instruction word seen through each encoding
    typedef union packed {
        rFormatT r;
        iFormatT i;
        bFormatT b;
    } instrU;

    typedef struct packed {
        logic zero;
        logic overflow;
        logic negative;
    } flagsT;

    typedef struct packed {
        logic       regWrite;
        logic       aluSrc;
        logic       memEnable;
        logic       memWrite;
        logic       memToReg;
        logic       pcRead;
        logic       rdSrc;
        logic       immByte;
        opcodeE     aluOp;
        logic [1:0] branch;
    } ctrlT;

    typedef struct packed {
        ctrlT        ctrl;
        logic [15:0] srcData1;
        logic [15:0] srcData2;
        logic [15:0] imm;
        logic [3:0]  dstReg;
    } execOpT;

    typedef struct packed {
        logic        en;
        logic [3:0]  regNum;
        logic [15:0] data;
    } writeBackT;

endpackage

// ==== decode/branchControl.sv ====
// ======================================================================
// Branch resolution. Checks the condition code against the flag
// register and selects pc+2, the PC-relative target or a register.
// ======================================================================

`timescale 1ns/1ns

module branchControl import cpuPkg::*; (
    input  logic [1:0]  branch,
    input  condE        cond,
    input  logic [8:0]  offset,
    input  flagsT       flags,
    input  logic [15:0] regTarget,
    input  logic [15:0] pc,
    output logic [15:0] nextPc,
    output logic        taken
);

    logic        condMet;
    logic [15:0] pcPlus2;
    logic [15:0] relTarget;

    always_comb begin
        unique case (cond)
            CondNe: condMet = !flags.zero;
            CondEq: condMet = flags.zero;
            CondGt: condMet = !flags.zero && !flags.negative;
            CondLt: condMet = flags.negative;
            CondGe: condMet = flags.zero || !flags.negative;
            CondLe: condMet = flags.negative || flags.zero;
            CondOv: condMet = flags.overflow;
            default: condMet = 1'b1;
        endcase
    end

    assign pcPlus2   = pc + 16'd2;
    // Offset counts instructions, so it is doubled
    assign relTarget = pcPlus2 + {{6{offset[8]}}, offset, 1'b0};

    assign taken = condMet && ((branch == BranchB) || (branch == BranchReg));

    always_comb begin
        unique case (branch)
            BranchB:    nextPc = condMet ? relTarget : pcPlus2;
            BranchReg:  nextPc = condMet ? regTarget : pcPlus2;
            BranchHalt: nextPc = pc;
            default:    nextPc = pcPlus2;
        endcase
    end

endmodule

// ==== decode/controlUnit.sv ====
// ======================================================================
// Opcode decoder. Produces the control struct for one instruction;
// the two unsupported opcodes come out as all-inactive control.
// ======================================================================

`timescale 1ns/1ns

module controlUnit import cpuPkg::*; (
    input  opcodeE opcode,
    output ctrlT   ctrl
);

    always_comb begin
        ctrl       = '0;
        ctrl.aluOp = opcode;
        unique case (opcode)
            OpAdd, OpSub, OpXor: begin
                ctrl.regWrite = 1'b1;
            end
            OpSll, OpSra, OpRor: begin
                ctrl.regWrite = 1'b1;
                ctrl.aluSrc   = 1'b1;
            end
            OpLw: begin
                ctrl.regWrite  = 1'b1;
                ctrl.aluSrc    = 1'b1;
                ctrl.memEnable = 1'b1;
                ctrl.memToReg  = 1'b1;
            end
            OpSw: begin
                ctrl.aluSrc    = 1'b1;
                ctrl.memEnable = 1'b1;
                ctrl.memWrite  = 1'b1;
            end
            OpLlb, OpLhb: begin
                ctrl.regWrite = 1'b1;
                ctrl.aluSrc   = 1'b1;
                ctrl.rdSrc    = 1'b1;
                ctrl.immByte  = 1'b1;
            end
            OpB:   ctrl.branch = BranchB;
            OpBr:  ctrl.branch = BranchReg;
            OpPcs: begin
                ctrl.regWrite = 1'b1;
                ctrl.pcRead   = 1'b1;
            end
            OpHlt: ctrl.branch = BranchHalt;
            // RED and PADDSB behave as no-ops
            default: begin
                ctrl = '0;
            end
        endcase
    end

endmodule

// ==== decode/decodeStage.sv ====
// ======================================================================
// Decode stage. Splits the instruction, picks source registers and the
// immediate, reads the register file and resolves the next PC.
// Purely combinational apart from the register file it contains.
// ======================================================================

`timescale 1ns/1ns

module decodeStage import cpuPkg::*; (
    input  instrU       instr,
    input  logic [15:0] pc,
    input  flagsT       flags,
    input  writeBackT   writeBack,
    input  logic        clk,
    input  logic        rstN,
    output execOpT      execOp,
    output logic [15:0] nextPc,
    output logic        taken,
    output logic        halt
);

    ctrlT        ctrl;
    logic [3:0]  srcReg1;
    logic [3:0]  srcReg2;
    logic [15:0] regData1;
    logic [15:0] regData2;
    logic [15:0] immExt;
    logic [15:0] pcPlus2;

    controlUnit controlUnit0 (
        .opcode (instr.r.opcode),
        .ctrl   (ctrl)
    );

    // LLB and LHB modify rd in place
    assign srcReg1 = ctrl.rdSrc ? instr.r.rd : instr.r.rs;
    // SW stores the value held in rd
    assign srcReg2 = ctrl.memWrite ? instr.r.rd : instr.r.rt;

    registerFile registerFile0 (
        .clk       (clk),
        .rstN      (rstN),
        .srcReg1   (srcReg1),
        .srcReg2   (srcReg2),
        .writeBack (writeBack),
        .srcData1  (regData1),
        .srcData2  (regData2)
    );

    // Byte immediate is zero-extended, the nibble is sign-extended
    assign immExt = ctrl.immByte ? {8'h00, instr.i.imm8}
                                 : {{12{instr.r.rt[3]}}, instr.r.rt};

    assign pcPlus2 = pc + 16'd2;

    assign execOp = '{
        ctrl:     ctrl,
        srcData1: ctrl.pcRead ? pcPlus2 : regData1,
        srcData2: regData2,
        imm:      immExt,
        dstReg:   instr.r.rd
    };

    branchControl branchControl0 (
        .branch    (ctrl.branch),
        .cond      (instr.b.cond),
        .offset    (instr.b.offset),
        .flags     (flags),
        .regTarget (regData1),
        .pc        (pc),
        .nextPc    (nextPc),
        .taken     (taken)
    );

    assign halt = (ctrl.branch == BranchHalt);

endmodule

// ==== decode/registerFile.sv ====
// ======================================================================
// Sixteen 16-bit architectural registers. Two combinational read
// ports and one write port committed at the rising clock edge.
// ======================================================================

`timescale 1ns/1ns

module registerFile import cpuPkg::*; (
    input  logic        clk,
    input  logic        rstN,
    input  logic [3:0]  srcReg1,
    input  logic [3:0]  srcReg2,
    input  writeBackT   writeBack,
    output logic [15:0] srcData1,
    output logic [15:0] srcData2
);

    logic [15:0] regs [16];

    // R0 is never written, so it keeps its reset value of zero
    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            for (int i = 0; i < 16; i++) begin
                regs[i] <= 16'h0000;
            end
        end else if (writeBack.en && (writeBack.regNum != 4'd0)) begin
            regs[writeBack.regNum] <= writeBack.data;
        end
    end

    assign srcData1 = regs[srcReg1];
    assign srcData2 = regs[srcReg2];

endmodule

// ==== files.f ====
+incdir+verification
common/cpuPkg.sv
decode/controlUnit.sv
decode/registerFile.sv
decode/branchControl.sv
decode/decodeStage.sv
src/fetchUnit.sv
src/executeStage.sv
src/cpuTop.sv
verification/cpuTb.sv

// ==== src/cpuTop.sv ====
// ======================================================================
// Core top level. Joins fetch, decode and execute; instruction memory
// sits outside and answers instrAddr combinationally on instr.
// ======================================================================

`timescale 1ns/1ns

module cpuTop import cpuPkg::*; #(
    parameter int DataWords = 64
) (
    input  logic        clk,
    input  logic        rstN,
    input  logic [15:0] instr,
    output logic [15:0] instrAddr,
    output logic        halted,
    output writeBackT   retire
);

    logic [15:0] nextPc;
    logic        halt;
    flagsT       flags;
    execOpT      execOp;

    fetchUnit fetchUnit0 (
        .clk       (clk),
        .rstN      (rstN),
        .nextPc    (nextPc),
        .halt      (halt),
        .instrAddr (instrAddr),
        .halted    (halted)
    );

    decodeStage decodeStage0 (
        .instr     (instrU'(instr)),
        .pc        (instrAddr),
        .flags     (flags),
        .writeBack (retire),
        .clk       (clk),
        .rstN      (rstN),
        .execOp    (execOp),
        .nextPc    (nextPc),
        .taken     (),
        .halt      (halt)
    );

    executeStage #(
        .DataWords (DataWords)
    ) executeStage0 (
        .clk       (clk),
        .rstN      (rstN),
        .execOp    (execOp),
        .halted    (halted),
        .flags     (flags),
        .writeBack (retire)
    );

endmodule

// ==== src/executeStage.sv ====
// ======================================================================
// Execute stage. ALU with saturating add/sub and shifts, the flag
// register, a word-addressed data memory and the write-back select.
// Nothing commits once the core has halted.
// ======================================================================

`timescale 1ns/1ns

module executeStage import cpuPkg::*; #(
    parameter int DataWords = 64
) (
    input  logic      clk,
    input  logic      rstN,
    input  execOpT    execOp,
    input  logic      halted,
    output flagsT     flags,
    output writeBackT writeBack
);

    localparam int AddrBits = $clog2(DataWords);

    ctrlT                ctrl;
    logic [15:0]         opA;
    logic [15:0]         opB;
    logic [3:0]          shamt;
    logic [16:0]         wideSum;
    logic                satOvf;
    logic [15:0]         satResult;
    logic [31:0]         rotWide;
    logic [15:0]         memAddr;
    logic [AddrBits-1:0] memIdx;
    logic [15:0]         memRead;
    logic [15:0]         aluResult;
    logic                setsAll;
    logic                setsZero;
    logic [15:0]         dataMem [DataWords];

    assign ctrl  = execOp.ctrl;
    assign opA   = execOp.srcData1;
    assign opB   = ctrl.aluSrc ? execOp.imm : execOp.srcData2;
    assign shamt = execOp.imm[3:0];

    // One extra sign bit, so signed overflow shows as bit 16 != bit 15
    assign wideSum = (ctrl.aluOp == OpSub) ? {opA[15], opA} - {opB[15], opB}
                                           : {opA[15], opA} + {opB[15], opB};
    assign satOvf    = wideSum[16] ^ wideSum[15];
    assign satResult = !satOvf ? wideSum[15:0]
                               : (wideSum[16] ? 16'h8000 : 16'h7FFF);

    assign rotWide = {opA, opA} >> shamt;

    // Base plus a word offset
    assign memAddr = opA + {execOp.imm[14:0], 1'b0};
    assign memIdx  = memAddr[AddrBits:1];
    assign memRead = dataMem[memIdx];

    always_comb begin
        unique case (ctrl.aluOp)
            OpAdd, OpSub: aluResult = satResult;
            OpXor:        aluResult = opA ^ opB;
            OpSll:        aluResult = opA << shamt;
            OpSra:        aluResult = $signed(opA) >>> shamt;
            OpRor:        aluResult = rotWide[15:0];
            OpLlb:        aluResult = {opA[15:8], opB[7:0]};
            OpLhb:        aluResult = {opB[7:0], opA[7:0]};
            OpPcs:        aluResult = opA;
            default:      aluResult = memAddr;
        endcase
    end

    assign setsAll  = ctrl.regWrite &&
                      ((ctrl.aluOp == OpAdd) || (ctrl.aluOp == OpSub));
    assign setsZero = ctrl.regWrite &&
                      ((ctrl.aluOp == OpXor) || (ctrl.aluOp == OpSll) ||
                       (ctrl.aluOp == OpSra) || (ctrl.aluOp == OpRor));

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            flags <= '0;
        end else if (!halted) begin
            if (setsAll) begin
                flags <= '{zero:     (aluResult == 16'h0000),
                           overflow: satOvf,
                           negative: aluResult[15]};
            end else if (setsZero) begin
                flags.zero <= (aluResult == 16'h0000);
            end
        end
    end

    always_ff @(posedge clk) begin
        if (ctrl.memEnable && ctrl.memWrite && !halted) begin
            dataMem[memIdx] <= execOp.srcData2;
        end
    end

    assign writeBack = '{
        en:     ctrl.regWrite && !halted,
        regNum: execOp.dstReg,
        data:   ctrl.memToReg ? memRead : aluResult
    };

endmodule

// ==== src/fetchUnit.sv ====
// ======================================================================
// Program counter and sticky halt flag. Loads the next PC from branch
// control each cycle until a halt is seen, then freezes until reset.
// ======================================================================

`timescale 1ns/1ns

module fetchUnit (
    input  logic        clk,
    input  logic        rstN,
    input  logic [15:0] nextPc,
    input  logic        halt,
    output logic [15:0] instrAddr,
    output logic        halted
);

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            instrAddr <= 16'h0000;
        end else if (!halted) begin
            instrAddr <= nextPc;
        end
    end

    // Stays set once HLT has been decoded
    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            halted <= 1'b0;
        end else if (halt) begin
            halted <= 1'b1;
        end
    end

endmodule

// ==== verification/cpuModel.svh ====
// ======================================================================
// Instruction-level model of the core and the random program builder.
// Included inside the testbench module, where it shares the LFSR and
// the instruction memory array.
// ======================================================================

`ifndef CPU_MODEL_SVH
`define CPU_MODEL_SVH

logic [15:0] mRegs [16];
logic [15:0] mMem [DataWords];
logic [15:0] mPc;
logic        mHalted;
logic        mZ;
logic        mV;
logic        mN;

task automatic resetModel();
    for (int i = 0; i < 16; i++) begin
        mRegs[i] = 16'h0000;
    end
    mPc = 16'h0000;
    mHalted = 1'b0;
    mZ = 1'b0;
    mV = 1'b0;
    mN = 1'b0;
endtask

function automatic logic condMet(input logic [2:0] cond);
    case (cond)
        3'd0: return !mZ;
        3'd1: return mZ;
        3'd2: return !mZ && !mN;
        3'd3: return mN;
        3'd4: return mZ || (!mZ && !mN);
        3'd5: return mN || mZ;
        3'd6: return mV;
        default: return 1'b1;
    endcase
endfunction

// One architectural step; exp gets the write-back the core should show
task automatic stepModel(input logic [15:0] w, output writeBackT exp);
    logic [3:0]  op;
    logic [3:0]  rd;
    logic [15:0] a;
    logic [15:0] b;
    logic [15:0] res;
    logic [15:0] addr;
    logic [15:0] next;
    int          sum;
    op = w[15:12];
    rd = w[11:8];
    a = mRegs[w[7:4]];
    b = mRegs[w[3:0]];
    addr = a + {{11{w[3]}}, w[3:0], 1'b0};
    res = 16'h0000;
    next = mPc + 16'd2;
    exp = '0;
    exp.regNum = rd;
    if (mHalted) begin
        return;
    end
    case (op)
        OpAdd, OpSub: begin
            sum = (op == OpAdd) ? $signed(a) + $signed(b) : $signed(a) - $signed(b);
            mV = (sum > 32767) || (sum < -32768);
            if (sum > 32767) res = 16'h7FFF;
            else if (sum < -32768) res = 16'h8000;
            else res = sum[15:0];
            mN = res[15];
            exp.en = 1'b1;
        end
        OpXor: res = a ^ b;
        OpSll: res = a << w[3:0];
        OpSra: res = $signed(a) >>> w[3:0];
        OpRor: begin
            res = a;
            repeat (w[3:0]) res = {res[0], res[15:1]};
        end
        OpLw: begin
            res = mMem[(addr >> 1) % DataWords];
            exp.en = 1'b1;
        end
        OpSw: mMem[(addr >> 1) % DataWords] = mRegs[rd];
        OpLlb: begin
            res = {mRegs[rd][15:8], w[7:0]};
            exp.en = 1'b1;
        end
        OpLhb: begin
            res = {w[7:0], mRegs[rd][7:0]};
            exp.en = 1'b1;
        end
        OpB: if (condMet(w[11:9])) next = mPc + 16'd2 + {{6{w[8]}}, w[8:0], 1'b0};
        OpBr: if (condMet(w[11:9])) next = a;
        OpPcs: begin
            res = mPc + 16'd2;
            exp.en = 1'b1;
        end
        OpHlt: begin
            mHalted = 1'b1;
            next = mPc;
        end
        default: ;
    endcase
    // Logic and shift ops only touch Z
    if (op inside {OpXor, OpSll, OpSra, OpRor}) begin
        exp.en = 1'b1;
    end
    if (op inside {OpAdd, OpSub, OpXor, OpSll, OpSra, OpRor}) begin
        mZ = (res == 16'h0000);
    end
    exp.data = res;
    if (exp.en && rd != 4'd0) begin
        mRegs[rd] = res;
    end
    mPc = next;
endtask

// Preamble, random body with forward-only branches, HLT at the end
task automatic buildProgram();
    int          n;
    int          t;
    logic [3:0]  op;
    logic [3:0]  dst;
    logic [15:0] target;
    n = 0;
    for (int i = 0; i < ProgLen; i++) begin
        prog[i] = 16'hF000;
        tgt[i] = -1;
        prot[i] = 1'b0;
    end
    for (int r = 1; r <= 12; r++) begin
        prog[n] = {OpLlb, 4'(r), 8'(randBits(8))};
        prog[n + 1] = {OpLhb, 4'(r), 8'(randBits(8))};
        n += 2;
    end
    // R13 is the memory base, words 8 to 23 get filled before any load
    prog[n] = {OpLlb, 4'd13, 8'h20};
    n++;
    for (int k = 0; k < 16; k++) begin
        prog[n] = {OpSw, 4'(1 + k % 12), 4'd13, 4'(k - 8)};
        n++;
    end
    while (n < ProgLen - 1) begin
        op = 4'(randBits(4));
        dst = 4'(randBits(4));
        if (dst >= 4'd13) dst = 4'd0;
        if (op == OpHlt || (op == OpBr && n + 3 > ProgLen - 1)) op = OpAdd;
        case (op)
            OpLw: prog[n] = {op, dst, 4'd13, 4'(randBits(4))};
            OpSw: prog[n] = {op, 4'(randBits(4)), 4'd13, 4'(randBits(4))};
            OpB: begin
                prog[n] = {op, 3'(randBits(3)), 9'h000};
                tgt[n] = n + 1 + int'(randBits(3));
            end
            OpBr: begin
                // R15 is loaded with the target just before the jump
                prog[n] = {OpLlb, 4'd15, 8'h00};
                prog[n + 1] = {OpLhb, 4'd15, 8'h00};
                prot[n + 1] = 1'b1;
                prot[n + 2] = 1'b1;
                n += 2;
                prog[n] = {op, 3'(randBits(3)), 1'b0, 4'd15, 4'd0};
                tgt[n] = n + 1 + int'(randBits(3));
            end
            OpPcs: prog[n] = {op, dst, 8'h00};
            default: prog[n] = {op, dst, 8'(randBits(8))};
        endcase
        n++;
    end
    // Targets never land inside an R15 load sequence
    for (int i = 0; i < ProgLen; i++) begin
        if (tgt[i] >= 0) begin
            t = tgt[i];
            while (t < ProgLen - 1 && prot[t]) t++;
            if (t > ProgLen - 1) t = ProgLen - 1;
            if (prog[i][15:12] == OpB) begin
                prog[i][8:0] = 9'(t - i - 1);
            end else begin
                target = 16'(2 * t);
                prog[i - 2][7:0] = target[7:0];
                prog[i - 1][7:0] = target[15:8];
            end
        end
    end
endtask

`endif

// ==== verification/cpuTb.sv ====
// ======================================================================
// Testbench for the 16-bit core. Runs a random program from a fixed
// seed, serves instruction memory and checks the retire trace, the
// instruction address and the halt flag against a model every cycle.
// ======================================================================

`timescale 1ns/1ns

module cpuTb import cpuPkg::*; ();

    localparam int  DataWords   = 64;
    localparam int  ProgLen     = 300;
    localparam int  ResetCycles = 16;
    localparam int  HaltCycles  = 8;
    localparam time ClkPeriod   = 100;

    logic        clk;
    logic        rstN;
    logic [15:0] instr;
    logic [15:0] instrAddr;
    logic        halted;
    writeBackT   retire;

    logic [15:0] prog [ProgLen];
    int          tgt [ProgLen];
    logic        prot [ProgLen];
    logic [16:0] lfsr = 17'd84995;
    int          errors = 0;

    cpuTop #(
        .DataWords (DataWords)
    ) dut0 (
        .clk       (clk),
        .rstN      (rstN),
        .instr     (instr),
        .instrAddr (instrAddr),
        .halted    (halted),
        .retire    (retire)
    );

    // Fibonacci LFSR with taps 17 and 14 stepped once per bit
    function automatic logic [15:0] randBits(input int n);
        logic [15:0] v;
        logic        fb;
        v = '0;
        for (int i = 0; i < n; i++) begin
            fb = lfsr[16] ^ lfsr[13];
            lfsr = {lfsr[15:0], fb};
            v = {v[14:0], fb};
        end
        return v;
    endfunction

    `include "cpuModel.svh"

    function automatic logic [15:0] fetchWord(input logic [15:0] addr);
        if (addr[15:1] < ProgLen) begin
            return prog[addr[15:1]];
        end
        return {OpHlt, 12'h000};
    endfunction

    task automatic checkValue(input string name, input logic [31:0] expected,
                              input logic [31:0] actual);
        if (actual !== expected) begin
            errors++;
            $display("FAIL %s expected %h actual %h", name, expected, actual);
        end
    endtask

    initial begin
        clk = 1'b0;
        forever #(ClkPeriod / 2) clk = ~clk;
    end

    initial begin
        #((ProgLen + ResetCycles + 50) * ClkPeriod);
        $display("Timeout: the core did not reach the end of the program in time");
        $display("Test failed");
        $finish;
    end

    initial begin
        writeBackT   exp;
        int          postHalt;
        logic [15:0] word;
        rstN = 1'b0;
        instr = 16'h0000;
        buildProgram();
        resetModel();
        repeat (ResetCycles) @(negedge clk);
        rstN = 1'b1;
        postHalt = 0;
        while (postHalt < HaltCycles) begin
            checkValue($sformatf("instrAddr @%h", mPc), mPc, instrAddr);
            checkValue($sformatf("halted @%h", mPc), mHalted, halted);
            instr = fetchWord(instrAddr);
            // The model runs from its own PC
            word = fetchWord(mPc);
            // Retire is combinational so it is sampled before the rising edge
            #(ClkPeriod / 4);
            stepModel(word, exp);
            checkValue($sformatf("retire.en %h", word), exp.en, retire.en);
            if (exp.en) begin
                checkValue($sformatf("retire.reg %h", word), exp.regNum, retire.regNum);
                checkValue($sformatf("retire.data %h", word), exp.data, retire.data);
            end
            if (mHalted) postHalt++;
            @(negedge clk);
        end
        $display("Errors: %0d", errors);
        if (errors == 0) begin
            $display("Test completed successfully");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

endmodule
